//--- project.f
src/md_pkg.sv
src/md_mult.sv
src/md_div.sv
src/md_unit.sv
verif/md_checker.sv
verif/md_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= md_unit_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SOURCES   := $(wildcard src/*.sv) $(wildcard verif/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/md_unit_tb.sv
`timescale 1ns/10ps

module md_unit_tb import md_pkg::*; ();

  localparam int unsigned W = DataWidthDefault;
  localparam int NameW       = 128;
  localparam int NumFixed    = 22;
  localparam int NumRand     = 8;
  localparam int NumRows     = NumFixed + NumRand;
  localparam int ClkPeriod   = 8;
  localparam int DriveDelay  = 1;
  localparam int ResetCycles = 4;

  logic          clk;
  logic          rst_n;
  logic          mult_en;
  logic          div_en;
  md_req_t       req;
  logic          ready;
  logic [W-1:0]  result;
  logic          valid;

  // Stimulus and expectation table, one entry per test
  logic [NameW-1:0] name_tab [NumRows];
  logic             kind_tab [NumRows];
  md_op_e           op_tab [NumRows];
  logic [1:0]       mode_tab [NumRows];
  logic [W-1:0]     a_tab [NumRows];
  logic [W-1:0]     b_tab [NumRows];
  logic [W-1:0]     exp_tab [NumRows];
  int               lat_tab [NumRows];
  int               delay_tab [NumRows];

  int               row_cnt;
  int               seed;
  int               limit = 0;
  int               cycle_cnt = 0;
  logic             report;
  logic [NameW-1:0] cur_name;
  logic [W-1:0]     cur_exp;
  int               cur_lat;
  int               err_cnt;
  int               done_cnt;

  md_unit #(
    .DataWidth(W)
  ) UUT (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .mult_en_i(mult_en),
    .div_en_i (div_en),
    .req_i    (req),
    .ready_i  (ready),
    .result_o (result),
    .valid_o  (valid)
  );

  md_checker #(
    .DataWidth(W),
    .NameW    (NameW)
  ) u_checker (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .mult_en_i    (mult_en),
    .div_en_i     (div_en),
    .req_i        (req),
    .ready_i      (ready),
    .result_i     (result),
    .valid_i      (valid),
    .name_i       (cur_name),
    .exp_result_i (cur_exp),
    .exp_latency_i(cur_lat),
    .report_i     (report),
    .err_cnt_o    (err_cnt),
    .done_cnt_o   (done_cnt)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // Reference model from the RISC-V M rules
  function automatic logic [W-1:0] expected_result(md_op_e op, logic [1:0] mode,
                                                   logic [W-1:0] a, logic [W-1:0] b);
    logic [2*W-1:0] ext_a;
    logic [2*W-1:0] ext_b;
    logic [2*W-1:0] prod;
    logic           neg_a;
    logic           neg_b;
    logic [W-1:0]   mag_a;
    logic [W-1:0]   mag_b;
    logic [W-1:0]   quo;
    logic [W-1:0]   rem;
    ext_a = mode[0] ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
    ext_b = mode[1] ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
    prod  = ext_a * ext_b;
    neg_a = mode[0] & a[W-1];
    neg_b = mode[1] & b[W-1];
    mag_a = neg_a ? -a : a;
    mag_b = neg_b ? -b : b;
    if (b == '0) begin
      quo = '1;
      rem = a;
    end else begin
      quo = mag_a / mag_b;
      rem = mag_a % mag_b;
      if (neg_a ^ neg_b) quo = -quo;
      if (neg_a) rem = -rem;
    end
    case (op)
      MD_OP_MULL: return prod[W-1:0];
      MD_OP_MULH: return prod[2*W-1:W];
      MD_OP_DIV:  return quo;
      default:    return rem;
    endcase
  endfunction

  function automatic int expected_latency(md_op_e op, logic [W-1:0] b);
    if (op == MD_OP_MULL) return 3;
    if (op == MD_OP_MULH) return 4;
    return (b == '0) ? 2 : 37;
  endfunction

  // Worst case per test plus slack for reset and the end of the run
  function automatic int cycle_budget();
    int sum;
    sum = 20;
    for (int i = 0; i < NumRows; i++) begin
      sum = sum + 37 + delay_tab[i] + 2;
    end
    return sum;
  endfunction

  task automatic add_row(input logic [NameW-1:0] name, input md_op_e op, input logic [1:0] mode,
                         input logic [W-1:0] a, input logic [W-1:0] b, input logic [W-1:0] exp,
                         input int lat, input int dly);
    name_tab[row_cnt]  = name;
    kind_tab[row_cnt]  = (op == MD_OP_DIV) || (op == MD_OP_REM);
    op_tab[row_cnt]    = op;
    mode_tab[row_cnt]  = mode;
    a_tab[row_cnt]     = a;
    b_tab[row_cnt]     = b;
    exp_tab[row_cnt]   = exp;
    lat_tab[row_cnt]   = lat;
    delay_tab[row_cnt] = dly;
    row_cnt            = row_cnt + 1;
  endtask

  task automatic fill_table();
    md_op_e       op;
    logic [1:0]   mode;
    logic [W-1:0] ra;
    logic [W-1:0] rb;
    int           pick;
    int           dly;
    row_cnt = 0;
    // Name, operator, mode, a, b, result, latency, ready delay
    add_row("mull_pos", MD_OP_MULL, 2'd3, 32'd7, 32'd6, 32'h0000002a, 3, 0);
    add_row("mull_neg", MD_OP_MULL, 2'd3, 32'hfffffffd, 32'd5, 32'hfffffff1, 3, 0);
    add_row("mull_unsigned", MD_OP_MULL, 2'd0, 32'h12345678, 32'h10, 32'h23456780, 3, 0);
    add_row("mulh_min_sq", MD_OP_MULH, 2'd3, 32'h80000000, 32'h80000000, 32'h40000000, 4, 0);
    add_row("mulh_ss", MD_OP_MULH, 2'd3, 32'hffffffff, 32'd5, 32'hffffffff, 4, 0);
    add_row("mulh_su", MD_OP_MULH, 2'd1, 32'hffffffff, 32'hffffffff, 32'hffffffff, 4, 0);
    add_row("mulh_uu", MD_OP_MULH, 2'd0, 32'hffffffff, 32'hffffffff, 32'hfffffffe, 4, 0);
    add_row("mulh_uu_small", MD_OP_MULH, 2'd0, 32'h80000000, 32'd4, 32'h00000002, 4, 0);
    add_row("div_neg", MD_OP_DIV, 2'd3, 32'hffffffec, 32'd3, 32'hfffffffa, 37, 0);
    add_row("rem_neg", MD_OP_REM, 2'd3, 32'hffffffec, 32'd3, 32'hfffffffe, 37, 0);
    add_row("divu", MD_OP_DIV, 2'd0, 32'hffffffec, 32'd3, 32'h5555554e, 37, 0);
    add_row("remu", MD_OP_REM, 2'd0, 32'hffffffec, 32'd3, 32'h00000002, 37, 0);
    add_row("div_neg_b", MD_OP_DIV, 2'd3, 32'd100, 32'hfffffff9, 32'hfffffff2, 37, 0);
    add_row("rem_neg_b", MD_OP_REM, 2'd3, 32'd100, 32'hfffffff9, 32'h00000002, 37, 0);
    add_row("div_overflow", MD_OP_DIV, 2'd3, 32'h80000000, 32'hffffffff, 32'h80000000, 37, 0);
    add_row("rem_overflow", MD_OP_REM, 2'd3, 32'h80000000, 32'hffffffff, 32'h00000000, 37, 0);
    add_row("div_zero", MD_OP_DIV, 2'd3, 32'd1234, 32'd0, 32'hffffffff, 2, 0);
    add_row("rem_zero", MD_OP_REM, 2'd3, 32'hdeadbeef, 32'd0, 32'hdeadbeef, 2, 0);
    add_row("hold_mull", MD_OP_MULL, 2'd3, 32'd1000, 32'hfffffc18, 32'hfff0bdc0, 3, 5);
    add_row("hold_divu", MD_OP_DIV, 2'd0, 32'd1000, 32'd7, 32'h0000008e, 37, 4);
    add_row("hold_mulh", MD_OP_MULH, 2'd3, 32'hffffffff, 32'hffffffff, 32'h00000000, 4, 3);
    add_row("hold_rem_zero", MD_OP_REM, 2'd3, 32'h00000055, 32'd0, 32'h00000055, 2, 2);
    for (int i = 0; i < NumRand; i++) begin
      op = md_op_e'(i % 4);
      ra = $random(seed);
      rb = $random(seed);
      pick = $unsigned($random(seed)) % 3;
      if (op == MD_OP_DIV || op == MD_OP_REM) begin
        mode = pick[0] ? 2'd3 : 2'd0;
      end else begin
        // MULHU, MULHSU and MULH
        mode = (pick == 2) ? 2'd3 : 2'(pick);
      end
      dly = $unsigned($random(seed)) % 3;
      add_row({"random_", 8'(48 + i)}, op, mode, ra, rb, expected_result(op, mode, ra, rb),
              expected_latency(op, rb), dly);
    end
  endtask

  task automatic apply_row(input int idx);
    @(posedge clk);
    #DriveDelay;
    req.op          = op_tab[idx];
    req.signed_mode = mode_tab[idx];
    req.op_a        = a_tab[idx];
    req.op_b        = b_tab[idx];
    cur_name        = name_tab[idx];
    cur_exp         = exp_tab[idx];
    cur_lat         = lat_tab[idx];
    mult_en         = ~kind_tab[idx];
    div_en          = kind_tab[idx];
    ready           = (delay_tab[idx] == 0);
    @(negedge clk);
    while (valid !== 1'b1) begin
      @(negedge clk);
    end
    // Back-pressure for the row's ready delay
    if (delay_tab[idx] > 0) begin
      repeat (delay_tab[idx]) @(posedge clk);
      #DriveDelay ready = 1'b1;
    end
    @(posedge clk);
    #DriveDelay;
    mult_en = 1'b0;
    div_en  = 1'b0;
    ready   = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (limit > 0 && cycle_cnt >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    mult_en  = 1'b0;
    div_en   = 1'b0;
    ready    = 1'b0;
    req      = '0;
    report   = 1'b0;
    cur_name = '0;
    cur_exp  = '0;
    cur_lat  = 0;
    seed     = 9791;
    fill_table();
    limit = cycle_budget();
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay rst_n = 1'b1;
    for (int i = 0; i < NumRows; i++) begin
      apply_row(i);
    end
    repeat (2) @(posedge clk);
    report = 1'b1;
    #1;
    if (err_cnt == 0 && done_cnt == NumRows) begin
      $display("PASS: all tests");
    end else begin
      if (done_cnt != NumRows) begin
        $display("Only %0d of %0d tests were accepted", done_cnt, NumRows);
      end
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- verif/md_checker.sv
`timescale 1ns/10ps

module md_checker import md_pkg::*; #(
  parameter int unsigned DataWidth = DataWidthDefault,
  parameter int unsigned NameW     = 128
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mult_en_i,
  input  logic                 div_en_i,
  input  md_req_t              req_i,
  input  logic                 ready_i,
  input  logic [DataWidth-1:0] result_i,
  input  logic                 valid_i,
  input  logic [NameW-1:0]     name_i,
  input  logic [DataWidth-1:0] exp_result_i,
  input  int                   exp_latency_i,
  input  logic                 report_i,
  output int                   err_cnt_o,
  output int                   done_cnt_o
);

  logic                 active = 1'b0;
  logic                 seen_valid = 1'b0;
  logic                 test_failed = 1'b0;
  int                   cycle = 0;
  logic [DataWidth-1:0] held_result = '0;
  int                   err_cnt = 0;
  int                   done_cnt = 0;
  int                   fail_cnt = 0;

  assign err_cnt_o  = err_cnt;
  assign done_cnt_o = done_cnt;

  task automatic note_failure();
    err_cnt = err_cnt + 1;
    if (active) begin
      test_failed = 1'b1;
    end
  endtask

  // Outputs sampled half a cycle after the rising edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      active = 1'b0;
      if (valid_i !== 1'b0 || result_i !== '0) begin
        $display("Outputs are not cleared in reset: valid_o=%b result_o=%h", valid_i, result_i);
        note_failure();
      end
    end else if (!(mult_en_i || div_en_i)) begin
      active = 1'b0;
      if (valid_i !== 1'b0) begin
        $display("valid_o is high while no enable is raised");
        note_failure();
      end
    end else begin
      if (!active) begin
        active      = 1'b1;
        seen_valid  = 1'b0;
        test_failed = 1'b0;
        cycle       = 0;
      end
      cycle = cycle + 1;
      if (!seen_valid) begin
        if (valid_i === 1'b1) begin
          seen_valid  = 1'b1;
          held_result = result_i;
          if (cycle != exp_latency_i) begin
            $display("%0s: valid_o came in cycle %0d instead of cycle %0d",
                     name_i, cycle, exp_latency_i);
            note_failure();
          end
        end
      end else if (valid_i !== 1'b1) begin
        $display("%0s: valid_o dropped before the result was accepted", name_i);
        note_failure();
      end else if (result_i !== held_result) begin
        $display("%0s: result_o changed from %h to %h while ready_i was low",
                 name_i, held_result, result_i);
        note_failure();
      end
      // Accepting cycle
      if (valid_i === 1'b1 && ready_i === 1'b1) begin
        if (result_i !== exp_result_i) begin
          $display("ERROR %0s: expected %h, actual %h", name_i, exp_result_i, result_i);
          note_failure();
        end
        done_cnt = done_cnt + 1;
        if (test_failed) begin
          fail_cnt = fail_cnt + 1;
        end
        $display("Test %0s a=%h b=%h %s", name_i, req_i.op_a, req_i.op_b,
                 test_failed ? "failed" : "ok");
        active = 1'b0;
      end
    end
  end

  always @(posedge report_i) begin
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             done_cnt, done_cnt - fail_cnt, fail_cnt, err_cnt);
  end

endmodule

//--- src/md_unit.sv
`timescale 1ns/10ps

module md_unit import md_pkg::*; #(
  parameter int unsigned DataWidth = DataWidthDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mult_en_i,
  input  logic                 div_en_i,
  input  md_req_t              req_i,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] result_o,
  output logic                 valid_o
);

  logic [DataWidth-1:0] mult_result;
  logic [DataWidth-1:0] div_result;
  logic                 mult_valid;
  logic                 div_valid;

  // Three or four cycle multiply
  md_mult #(
    .DataWidth(DataWidth)
  ) u_mult (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .en_i    (mult_en_i),
    .req_i   (req_i),
    .ready_i (ready_i),
    .result_o(mult_result),
    .valid_o (mult_valid)
  );

  // Long division, or the zero divisor shortcut
  md_div #(
    .DataWidth(DataWidth)
  ) u_div (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .en_i    (div_en_i),
    .req_i   (req_i),
    .ready_i (ready_i),
    .result_o(div_result),
    .valid_o (div_valid)
  );

  // Only one enable is high at a time
  assign result_o = div_en_i ? div_result : mult_result;
  assign valid_o  = mult_valid | div_valid;

endmodule

//--- src/md_div.sv
`timescale 1ns/10ps

module md_div import md_pkg::*; #(
  parameter int unsigned DataWidth = DataWidthDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_i,
  input  md_req_t              req_i,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] result_o,
  output logic                 valid_o
);

  localparam int unsigned CntW = md_cnt_w(DataWidth);

  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    CHANGE_SIGN,
    FINISH
  } div_state_e;

  div_state_e state_q, state_d;

  logic [DataWidth-1:0] op_a;
  logic [DataWidth-1:0] op_b;
  logic                 is_div;
  logic                 div_by_zero;
  logic                 sign_a;
  logic                 sign_b;
  logic                 div_change_sign;
  logic                 rem_change_sign;

  // Subtractor shared by the absolute value, compare and sign steps
  logic [DataWidth:0]   sub_a;
  logic [DataWidth:0]   sub_b;
  logic [DataWidth:0]   sub_res;

  logic [CntW-1:0]      cnt_q, cnt_d;
  logic [DataWidth:0]   rem_q, rem_d;
  logic [DataWidth-1:0] quo_q, quo_d;
  logic [DataWidth-1:0] num_q, num_d;
  logic [DataWidth-1:0] den_q, den_d;

  logic                 is_greater_equal;
  logic [DataWidth-1:0] next_rem;
  logic [DataWidth-1:0] next_quo;
  logic [DataWidth-1:0] one_shift;
  logic                 div_hold;
  logic                 div_en_int;

  assign op_a        = req_i.op_a[DataWidth-1:0];
  assign op_b        = req_i.op_b[DataWidth-1:0];
  assign is_div      = (req_i.op == MD_OP_DIV);
  assign div_by_zero = (op_b == '0);

  assign sign_a          = req_i.signed_mode[0] & op_a[DataWidth-1];
  assign sign_b          = req_i.signed_mode[1] & op_b[DataWidth-1];
  assign div_change_sign = sign_a ^ sign_b;
  // Remainder follows the dividend
  assign rem_change_sign = sign_a;

  assign div_en_int = en_i & ~div_hold;

  assign sub_res = sub_a - sub_b;

  // Shifted remainder may carry one bit above the word; that alone means it exceeds the divisor
  assign is_greater_equal = rem_q[DataWidth] | ~sub_res[DataWidth];
  assign next_rem         = is_greater_equal ? sub_res[DataWidth-1:0] : rem_q[DataWidth-1:0];
  assign one_shift        = {{(DataWidth - 1){1'b0}}, 1'b1} << cnt_q;
  assign next_quo         = is_greater_equal ? (quo_q | one_shift) : quo_q;

  always_comb begin
    state_d  = state_q;
    cnt_d    = cnt_q - 1'b1;
    rem_d    = rem_q;
    quo_d    = quo_q;
    num_d    = num_q;
    den_d    = den_q;
    sub_a    = '0;
    sub_b    = {1'b0, op_b};
    valid_o  = 1'b0;
    div_hold = 1'b0;

    unique case (state_q)
      IDLE: begin
        // Zero divisor skips the division with the fixed RISC-V results
        if (is_div) begin
          rem_d = '1;
        end else begin
          rem_d = {1'b0, op_a};
        end
        state_d = div_by_zero ? FINISH : ABS_A;
        cnt_d   = CntW'(DataWidth - 1);
      end

      ABS_A: begin
        sub_a   = '0;
        sub_b   = {1'b0, op_a};
        num_d   = sign_a ? sub_res[DataWidth-1:0] : op_a;
        quo_d   = '0;
        cnt_d   = CntW'(DataWidth - 1);
        state_d = ABS_B;
      end

      ABS_B: begin
        sub_a = '0;
        sub_b = {1'b0, op_b};
        den_d = sign_b ? sub_res[DataWidth-1:0] : op_b;
        // First numerator bit enters the remainder
        rem_d   = {{DataWidth{1'b0}}, num_q[DataWidth-1]};
        cnt_d   = CntW'(DataWidth - 1);
        state_d = COMP;
      end

      COMP: begin
        sub_a   = rem_q;
        sub_b   = {1'b0, den_q};
        rem_d   = {next_rem, num_q[cnt_d]};
        quo_d   = next_quo;
        state_d = (cnt_q == CntW'(1)) ? LAST : COMP;
      end

      LAST: begin
        // Final step keeps only what the operator returns
        sub_a = rem_q;
        sub_b = {1'b0, den_q};
        if (is_div) begin
          rem_d = {1'b0, next_quo};
        end else begin
          rem_d = {1'b0, next_rem};
        end
        state_d = CHANGE_SIGN;
      end

      CHANGE_SIGN: begin
        sub_a = '0;
        sub_b = {1'b0, rem_q[DataWidth-1:0]};
        if (is_div ? div_change_sign : rem_change_sign) begin
          rem_d = {1'b0, sub_res[DataWidth-1:0]};
        end
        state_d = FINISH;
      end

      FINISH: begin
        // Stay here until the consumer takes the result
        valid_o  = 1'b1;
        div_hold = ~ready_i;
        state_d  = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      rem_q   <= '0;
    end else if (div_en_int) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      rem_q   <= rem_d;
    end
  end

  // Operand and quotient registers
  always_ff @(posedge clk_i) begin
    if (div_en_int) begin
      quo_q <= quo_d;
      num_q <= num_d;
      den_q <= den_d;
    end
  end

  assign result_o = rem_q[DataWidth-1:0];

endmodule

//--- src/md_mult.sv
`timescale 1ns/10ps

module md_mult import md_pkg::*; #(
  parameter int unsigned DataWidth = DataWidthDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_i,
  input  md_req_t              req_i,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] result_o,
  output logic                 valid_o
);

  localparam int unsigned HalfW = md_half_w(DataWidth);
  localparam int unsigned AccW  = DataWidth + 2;

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e state_q, state_d;

  logic [DataWidth-1:0] op_a;
  logic [DataWidth-1:0] op_b;
  logic [HalfW-1:0]     mul_op_a;
  logic [HalfW-1:0]     mul_op_b;
  logic                 sign_a;
  logic                 sign_b;
  logic                 signed_mult;
  logic                 is_mull;
  logic [AccW-1:0]      accum;
  logic [AccW-1:0]      mac_res;
  logic [AccW-1:0]      acc_q, acc_d;
  logic                 mult_hold;
  logic                 mult_en_int;

  assign op_a        = req_i.op_a[DataWidth-1:0];
  assign op_b        = req_i.op_b[DataWidth-1:0];
  assign signed_mult = (req_i.signed_mode != 2'b00);
  assign is_mull     = (req_i.op == MD_OP_MULL);

  // Registers advance only while enabled and not holding a finished result
  assign mult_en_int = en_i & ~mult_hold;

  // One 17x17 signed MAC; each half carries an extra sign bit
  assign mac_res = $signed({sign_a, mul_op_a}) * $signed({sign_b, mul_op_b}) + $signed(accum);

  always_comb begin
    mul_op_a  = op_a[HalfW-1:0];
    mul_op_b  = op_b[HalfW-1:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = '0;
    acc_d     = mac_res;
    state_d   = state_q;
    valid_o   = 1'b0;
    mult_hold = 1'b0;

    unique case (state_q)
      ALBL: begin
        // Low halves, always unsigned
        accum   = '0;
        acc_d   = mac_res;
        state_d = ALBH;
      end

      ALBH: begin
        // al * bh, added to the upper half of al * bl
        mul_op_b = op_b[DataWidth-1:HalfW];
        sign_b   = req_i.signed_mode[1] & op_b[DataWidth-1];
        accum    = {{(HalfW + 2){1'b0}}, acc_q[DataWidth-1:HalfW]};
        if (is_mull) begin
          acc_d = {2'b00, mac_res[HalfW-1:0], acc_q[HalfW-1:0]};
        end else begin
          acc_d = mac_res;
        end
        state_d = AHBL;
      end

      AHBL: begin
        // ah * bl
        mul_op_a = op_a[DataWidth-1:HalfW];
        sign_a   = req_i.signed_mode[0] & op_a[DataWidth-1];
        if (is_mull) begin
          // Only the low half of the partial sum matters for the low word
          accum     = {{(HalfW + 2){1'b0}}, acc_q[DataWidth-1:HalfW]};
          acc_d     = {2'b00, mac_res[HalfW-1:0], acc_q[HalfW-1:0]};
          valid_o   = 1'b1;
          mult_hold = ~ready_i;
          state_d   = ALBL;
        end else begin
          accum   = acc_q;
          acc_d   = mac_res;
          state_d = AHBH;
        end
      end

      AHBH: begin
        // ah * bh plus the shifted sum of the cross products
        mul_op_a  = op_a[DataWidth-1:HalfW];
        mul_op_b  = op_b[DataWidth-1:HalfW];
        sign_a    = req_i.signed_mode[0] & op_a[DataWidth-1];
        sign_b    = req_i.signed_mode[1] & op_b[DataWidth-1];
        accum     = {{HalfW{signed_mult & acc_q[AccW-1]}}, acc_q[AccW-1:HalfW]};
        acc_d     = mac_res;
        valid_o   = 1'b1;
        mult_hold = ~ready_i;
        state_d   = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
      acc_q   <= '0;
    end else if (mult_en_int) begin
      state_q <= state_d;
      acc_q   <= acc_d;
    end
  end

  // Low word for MULL, upper word of the full product for MULH
  assign result_o = acc_d[DataWidth-1:0];

endmodule

//--- src/md_pkg.sv
package md_pkg;

  // Operand width used when the top level does not override it
  localparam int unsigned DataWidthDefault = 32;

  // Operator class; the signedness comes separately from the signed mode
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // One request to the unit, held stable while the enable is high
  typedef struct packed {
    md_op_e                      op;
    // Bit 0 marks operand a as signed, bit 1 marks operand b as signed
    logic [1:0]                  signed_mode;
    logic [DataWidthDefault-1:0] op_a;
    logic [DataWidthDefault-1:0] op_b;
  } md_req_t;

  // Width of one operand half in the multiplier
  function automatic int unsigned md_half_w(int unsigned width);
    int unsigned half;
    half = width / 2;
    return half;
  endfunction

  // Width of the divider bit counter
  function automatic int unsigned md_cnt_w(int unsigned width);
    int unsigned cnt;
    cnt = $clog2(width);
    return cnt;
  endfunction

endpackage
